/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_TEXT ?= TEST RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  build  build the simulation only"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input logic clk,
    mem_bus_if.mem bus
);
    import mips_pkg::*;

    // storage keeps every word byte-reversed
    word_t mem [dram_words];

    logic [dram_addr_bits-1:0] word_idx;

    // swap byte order, same function both directions
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // value the core should see at word k after power-up
    function automatic word_t preload_value(input int unsigned k);
        word_t prod;
        addr_t byte_addr;
        prod = preload_step * word_t'(k + 2);
        byte_addr = word_t'(k) << 2;
        // series, forced negative by setting bit 31
        if (k < series_words) begin
            return {1'b1, prod[30:0]};
        end
        // terminator word right after the series
        if (k == series_words) begin
            return '0;
        end
        // all-ones block from fill_base
        if (byte_addr >= fill_base && byte_addr < fill_base + 4 * fill_words) begin
            return '1;
        end
        return '0;
    endfunction

    // preload the whole array in storage byte order
    initial begin
        for (int i = 0; i < dram_words; i++) begin
            mem[i] = swap_bytes(preload_value(i));
        end
    end

    // word index from byte address
    assign word_idx = bus.addr[dram_addr_bits+1:2];

    // combinational read, zero while not reading
    assign bus.readdata = bus.read ? swap_bytes(mem[word_idx]) : '0;

    // single-cycle write
    always @(posedge clk) begin
        if (bus.write) begin
            mem[word_idx] <= swap_bytes(bus.writedata);
        end
    end

endmodule

`default_nettype wire

/* instr_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_ram (
    input  logic            clk,
    input  logic            load_en,
    input  mips_pkg::addr_t load_addr,
    input  mips_pkg::word_t load_data,
    input  mips_pkg::addr_t fetch_addr,
    output mips_pkg::word_t instr
);
    import mips_pkg::*;

    // program store, filled while reset is held
    word_t mem [iram_words];

    logic [iram_addr_bits-1:0] load_idx;
    logic [iram_addr_bits-1:0] fetch_idx;

    // load port is word indexed
    assign load_idx = load_addr[iram_addr_bits-1:0];

    // fetch uses a byte address
    assign fetch_idx = fetch_addr[iram_addr_bits+1:2];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end
    end

    // instruction available in the same cycle as pc
    assign instr = mem[fetch_idx];

endmodule

`default_nettype wire

/* mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import mips_pkg::*;

    // byte address, word aligned in practice
    addr_t addr;
    logic  read;
    logic  write;
    word_t writedata;
    // valid in the same cycle while read is high
    word_t readdata;

    // core side drives the request
    modport cpu (
        output addr, read, write, writedata,
        input  readdata
    );

    // memory side answers combinationally
    modport mem (
        input  addr, read, write, writedata,
        output readdata
    );

endinterface

`default_nettype wire

/* mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic               clk,
    input  logic               reset,
    output mips_pkg::addr_t    fetch_addr,
    input  mips_pkg::word_t    instr,
    output mips_pkg::reg_idx_t rs_idx,
    output mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::word_t    rs_val,
    input  mips_pkg::word_t    rt_val,
    output logic               wr_en,
    output mips_pkg::reg_idx_t wr_idx,
    output mips_pkg::word_t    wr_val,
    mem_bus_if.cpu             dbus,
    output logic               running
);
    import mips_pkg::*;

    // control state
    addr_t       pc_q;
    addr_t       pc_d;
    core_state_e state_q;
    core_state_e state_d;
    logic        running_q;
    logic        active;

    // decoded fields
    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rd_idx;
    word_t    imm_sext;

    // instruction class
    logic is_addu;
    logic is_addiu;
    logic is_lw;
    logic is_sw;
    logic is_beq;
    logic is_halt;

    // datapath
    word_t alu_b;
    word_t sum;
    addr_t pc_plus4;
    addr_t branch_target;
    logic  take_branch;

    // field split
    assign opcode   = opcode_e'(instr[31:26]);
    assign funct    = funct_e'(instr[5:0]);
    assign rs_idx   = instr[25:21];
    assign rt_idx   = instr[20:16];
    assign rd_idx   = instr[15:11];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};

    // subset decode, anything else falls through as a no-op
    assign is_addu  = (opcode == op_special) && (funct == fn_addu);
    assign is_addiu = (opcode == op_addiu);
    assign is_lw    = (opcode == op_lw);
    assign is_sw    = (opcode == op_sw);
    assign is_beq   = (opcode == op_beq);
    // only jr $0 is meaningful, it stops the core
    assign is_halt  = (opcode == op_special) && (funct == fn_jr) && (rs_idx == '0);

    // retire one instruction per edge once out of reset and not halted
    // running_q already falls on the halt edge
    assign active = running_q;

    // shared adder for addu, addiu and the load/store address
    assign alu_b = is_addu ? rt_val : imm_sext;
    assign sum   = rs_val + alu_b;

    // data bus, strobes low unless retiring
    assign dbus.addr      = sum;
    assign dbus.writedata = rt_val;
    assign dbus.read      = active && is_lw;
    assign dbus.write     = active && is_sw;

    // write-back: rd for addu, rt for addiu and lw
    assign wr_en  = active && (is_addu || is_addiu || is_lw);
    assign wr_idx = is_addu ? rd_idx : rt_idx;
    // load data comes back in the same cycle
    assign wr_val = is_lw ? dbus.readdata : sum;

    // branch, no delay slot
    assign pc_plus4      = pc_q + 32'd4;
    assign branch_target = pc_plus4 + (imm_sext << 2);
    assign take_branch   = is_beq && (rs_val == rt_val);

    always_comb begin
        pc_d    = pc_q;
        state_d = state_q;
        if (active) begin
            if (is_halt) begin
                // pc parks on the jr
                state_d = st_halted;
            end else if (take_branch) begin
                pc_d = branch_target;
            end else begin
                pc_d = pc_plus4;
            end
        end
    end

    // pc held at zero while the program loads
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q      <= '0;
            state_q   <= st_run;
            running_q <= 1'b0;
        end else begin
            pc_q      <= pc_d;
            state_q   <= state_d;
            // rises on first edge after reset, falls with the halt
            running_q <= (state_d == st_run);
        end
    end

    assign fetch_addr = pc_q;
    assign running    = running_q;

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcode, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'd0,
        op_beq     = 6'd4,
        op_addiu   = 6'd9,
        op_lw      = 6'd35,
        op_sw      = 6'd43
    } opcode_e;

    // function field of special instructions, bits 5:0
    typedef enum logic [5:0] {
        fn_jr   = 6'd8,
        fn_addu = 6'd33
    } funct_e;

    // core only runs or sits halted after jr $0
    typedef enum logic {
        st_run,
        st_halted
    } core_state_e;

    // memory depths in words
    localparam int dram_words = 4096;
    localparam int iram_words = 1024;
    localparam int dram_addr_bits = $clog2(dram_words);
    localparam int iram_addr_bits = $clog2(iram_words);

    // data memory preload: arithmetic series then an all-ones block
    localparam word_t preload_step = 32'hdcba1234;
    localparam int    series_words = 28;
    localparam addr_t fill_base    = 32'h100;
    localparam int    fill_words   = 29;

endpackage

`default_nettype wire

/* mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        prog_write,
    input  logic [31:0] prog_address,
    input  logic [31:0] prog_data,
    output logic        running,
    output logic [31:0] v0
);
    import mips_pkg::*;

    // fetch path
    addr_t fetch_addr;
    word_t instr;

    // register file ports
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_val;
    word_t    rt_val;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_val;

    // core to data memory
    mem_bus_if u_dbus ();

    mips_core u_core (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_val     (wr_val),
        .dbus       (u_dbus.cpu),
        .running    (running)
    );

    // program loaded through the top-level port
    instr_ram u_instr_ram (
        .clk        (clk),
        .load_en    (prog_write),
        .load_addr  (prog_address),
        .load_data  (prog_data),
        .fetch_addr (fetch_addr),
        .instr      (instr)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wr_en  (wr_en),
        .wr_idx (wr_idx),
        .wr_val (wr_val),
        .v0     (v0)
    );

    data_ram u_data_ram (
        .clk (clk),
        .bus (u_dbus.mem)
    );

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_val,
    output mips_pkg::word_t    rt_val,
    input  logic               wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_val,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    // 32 general registers, $0 kept at zero
    word_t regs [32];

    // clear all on reset, drop writes to $0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_val;
        end
    end

    // two asynchronous read ports
    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];

    // v0 tap for the result port
    assign v0 = regs[2];

endmodule

`default_nettype wire

/* tb_mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_top;
    import mips_pkg::*;

    localparam int num_rows         = 11;
    localparam int prog_slots       = 10;
    localparam int reset_cycles     = 10;
    localparam int post_halt_cycles = 5;
    // preload rule, series length and size of the all-ones block
    localparam int    series_len = 28;
    localparam int    fill_len   = 29;
    // just past the all-ones block, zero after power-up
    localparam addr_t store_addr = 32'h174;

    logic        clk;
    logic        reset;
    logic        prog_write;
    logic [31:0] prog_address;
    logic [31:0] prog_data;
    logic        running;
    logic [31:0] v0;

    // test table: program, expected v0, expected retired cycles
    word_t prog_table [num_rows][prog_slots];
    int    prog_len [num_rows];
    word_t exp_v0 [num_rows];
    int    exp_cycles [num_rows];
    int    n_rows;
    word_t prog_q [$];

    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    int          cycle_limit;

    mips_top u_mips_top (
        .clk          (clk),
        .reset        (reset),
        .prog_write   (prog_write),
        .prog_address (prog_address),
        .prog_data    (prog_data),
        .running      (running),
        .v0           (v0)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
            stop_on_failure("value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: time %0t signal %s got %b expected %b", $time, name, got, exp);
            stop_on_failure("flag mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error: time %0t signal %s got %0d expected %0d", $time, name, got, exp);
            stop_on_failure("cycle count mismatch");
        end
    endtask

    // guard against a core that never halts
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: core still running after %0d cycles", cycle_count);
            stop_on_failure("timeout");
        end
    end

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // 15-bit positive immediate, one step per bit
    function automatic word_t random_imm();
        word_t v;
        v = '0;
        for (int i = 0; i < 15; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // instruction encoders
    function automatic word_t enc_itype(input opcode_e op, input reg_idx_t rs,
                                        input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_addu(input reg_idx_t rd, input reg_idx_t rs,
                                       input reg_idx_t rt);
        return {op_special, rs, rt, rd, 5'd0, fn_addu};
    endfunction

    function automatic word_t enc_jr_zero();
        return {op_special, 5'd0, 15'd0, fn_jr};
    endfunction

    // power-up value at a byte address as the core sees it
    function automatic word_t expected_preload(input addr_t a);
        word_t       prod;
        int unsigned k;
        k = a >> 2;
        prod = preload_step * (k + 2);
        if (k < series_len) begin
            return {1'b1, prod[30:0]};
        end
        if (k == series_len) begin
            return '0;
        end
        if (a >= fill_base && a < fill_base + 4 * fill_len) begin
            return '1;
        end
        return '0;
    endfunction

    // move the staged program into the next table row
    task automatic commit_row(input word_t v0_value, input int cycles);
        for (int i = 0; i < prog_slots; i++) begin
            prog_table[n_rows][i] = (i < prog_q.size()) ? prog_q[i] : '0;
        end
        prog_len[n_rows]   = prog_q.size();
        exp_v0[n_rows]     = v0_value;
        exp_cycles[n_rows] = cycles;
        n_rows++;
        prog_q.delete();
    endtask

    task automatic build_table();
        word_t imm_a;
        word_t imm_b;
        word_t imm_c;
        word_t stored;
        addr_t lw_addrs [6];
        // addiu/addu chain, two adds of a negative preload word force a wrap
        imm_a = random_imm();
        imm_b = random_imm();
        imm_c = random_imm();
        prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd2, imm_a[15:0]));
        prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd3, imm_b[15:0]));
        prog_q.push_back(enc_addu(5'd2, 5'd2, 5'd3));
        prog_q.push_back(enc_itype(op_addiu, 5'd2, 5'd2, imm_c[15:0]));
        prog_q.push_back(enc_itype(op_lw, 5'd0, 5'd5, 16'd20));
        prog_q.push_back(enc_addu(5'd2, 5'd2, 5'd5));
        prog_q.push_back(enc_addu(5'd2, 5'd2, 5'd5));
        prog_q.push_back(enc_jr_zero());
        // must never retire
        prog_q.push_back(enc_itype(op_addiu, 5'd2, 5'd2, 16'd1));
        commit_row(imm_a + imm_b + imm_c + 2 * expected_preload(32'd20), 8);
        // store a computed value, read it back
        imm_a = random_imm();
        stored = imm_a + imm_a;
        prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd3, imm_a[15:0]));
        prog_q.push_back(enc_addu(5'd3, 5'd3, 5'd3));
        prog_q.push_back(enc_itype(op_sw, 5'd0, 5'd3, store_addr[15:0]));
        prog_q.push_back(enc_itype(op_lw, 5'd0, 5'd2, store_addr[15:0]));
        prog_q.push_back(enc_jr_zero());
        commit_row(stored, 5);
        // single loads: series ends, terminator, fill block, neighbour, stored word
        lw_addrs = '{32'h0, 32'd108, 32'd112, fill_base + 32'd8, 32'h170, store_addr};
        foreach (lw_addrs[i]) begin
            prog_q.push_back(enc_itype(op_lw, 5'd0, 5'd2, lw_addrs[i][15:0]));
            prog_q.push_back(enc_jr_zero());
            commit_row((lw_addrs[i] == store_addr) ? stored : expected_preload(lw_addrs[i]), 2);
        end
        // beq taken skips the addiu, not taken falls through
        for (int eq = 1; eq >= 0; eq--) begin
            imm_a = random_imm();
            imm_b = random_imm();
            prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd2, imm_a[15:0]));
            prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd3, 16'd5));
            prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd4, (eq != 0) ? 16'd5 : 16'd6));
            prog_q.push_back(enc_itype(op_beq, 5'd3, 5'd4, 16'd1));
            prog_q.push_back(enc_itype(op_addiu, 5'd2, 5'd2, imm_b[15:0]));
            prog_q.push_back(enc_jr_zero());
            commit_row((eq != 0) ? imm_a : imm_a + imm_b, (eq != 0) ? 5 : 6);
        end
        // three-pass loop with a backward beq, 2 + 4 + 4 + 3 + 1 retired
        prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd2, 16'd0));
        prog_q.push_back(enc_itype(op_addiu, 5'd0, 5'd3, 16'd3));
        prog_q.push_back(enc_itype(op_addiu, 5'd2, 5'd2, 16'd7));
        prog_q.push_back(enc_itype(op_addiu, 5'd3, 5'd3, 16'hffff));
        prog_q.push_back(enc_itype(op_beq, 5'd3, 5'd0, 16'd1));
        prog_q.push_back(enc_itype(op_beq, 5'd0, 5'd0, 16'hfffc));
        prog_q.push_back(enc_jr_zero());
        commit_row(32'd21, 14);
    endtask

    task automatic run_row(input int r);
        int cycles;
        // load while reset is held
        @(posedge clk);
        reset <= 1'b1;
        for (int c = 0; c < reset_cycles; c++) begin
            prog_write   <= 1'b1;
            prog_address <= c;
            prog_data    <= prog_table[r][c];
            @(posedge clk);
        end
        prog_write <= 1'b0;
        reset      <= 1'b0;
        @(negedge clk);
        check_flag("running", running, 1'b0);
        check_word("v0", v0, '0);
        // first edge after release
        @(posedge clk);
        @(negedge clk);
        check_flag("running", running, 1'b1);
        cycles = 0;
        while (running) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        check_count("retired_cycles", cycles, exp_cycles[r]);
        check_word("v0", v0, exp_v0[r]);
        // halted core stays quiet
        for (int i = 0; i < post_halt_cycles; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("running", running, 1'b0);
            check_word("v0", v0, exp_v0[r]);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        prog_write   = 1'b0;
        prog_address = '0;
        prog_data    = '0;
        lfsr_state   = 16'd6;
        n_rows       = 0;
        build_table();
        // budget per row: reset, program length, slack
        cycle_limit = 0;
        for (int r = 0; r < n_rows; r++) begin
            cycle_limit += reset_cycles + prog_len[r] + 20;
        end
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
mips_pkg.sv
mem_bus_if.sv
data_ram.sv
instr_ram.sv
reg_file.sv
mips_core.sv
mips_top.sv
tb_mips_top.sv
